// File: include/mx_params.svh
`ifndef MX_PARAMS_SVH
`define MX_PARAMS_SVH

// ==========================================================================
// MXINT block format
// ==========================================================================

// Mantissas sharing one exponent
`define MX_BLOCK_SIZE 4

`define MX_IN_MAN_WIDTH 8
`define MX_IN_EXP_WIDTH 6

`define MX_OUT_MAN_WIDTH 4
`define MX_OUT_EXP_WIDTH 6

// Puts the largest magnitude in the top magnitude bit of the output mantissa
`define MX_EXP_OFFSET (`MX_OUT_MAN_WIDTH - 2)

// ==========================================================================
// Buffering
// ==========================================================================

`define MX_FIFO_DEPTH 2  // Whole blocks, power of two

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the MXINT cast testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_mxint_cast -o tb_mxint_cast > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_mxint_cast > "$LOG" 2>&1 \
  && ! grep -q "SIMULATION FAILED" "$LOG" \
  && echo "Run passed, see $LOG" \
  || { echo "Run failed, see $LOG"; exit 1; }

// File: testbench/mxint_cast_input.txt
# in_m0 in_m1 in_m2 in_m3 in_exp  out_m0 out_m1 out_m2 out_m3 out_exp
# All hex, two's complement, element 0 first
64 ce 19 03 00  6 c 1 0 04
f9 0d ff 28 05  f 1 f 5 08
7f 81 40 c0 36  7 8 4 c 3a
fd fb f7 ef 02  f e d b 04
01 02 03 00 00  2 4 6 0 3f
64 9c 05 fb 1f  7 8 5 b 1f
14 e2 09 00 1d  5 8 2 0 1f
32 0c fe 21 1e  7 6 f 7 1f
01 ff 00 01 21  2 e 0 2 20
00 00 00 01 20  0 0 0 1 20
03 fe 01 fd 1f  6 c 2 a 1e
64 03 ff 00 20  6 0 f 0 24
00 00 00 00 05  0 0 0 0 03
00 00 00 00 00  0 0 0 0 3e
80 00 00 00 00  c 0 0 0 05
80 7f ff 01 3d  c 3 f 0 02
04 fc 00 00 00  4 c 0 0 00
f8 07 00 00 0a  c 3 0 0 0b
ff ff ff ff 00  c c c c 3e
fe 01 00 00 01  c 2 0 0 00
60 df 46 11 2c  6 d 4 1 30
bf 02 08 10 0c  b 0 0 1 10

// File: testbench/mxint_cast_sva.sv
`timescale 1ns/1ps

`include "mx_params.svh"

module mxint_cast_sva (
  input logic                                        clk,
  input logic                                        arst_n,
  input logic                                        data_in_valid,
  input logic                                        data_in_ready,
  input logic [`MX_BLOCK_SIZE*`MX_OUT_MAN_WIDTH-1:0] mdata_out,
  input mx_pkg::out_exp_t                            edata_out,
  input logic                                        data_out_valid,
  input logic                                        data_out_ready
);

  // No output while in reset
  assert property (@(posedge clk) !arst_n |-> !data_out_valid)
    else $error("data_out_valid high during reset");

  // Stalled block must hold
  assert property (@(posedge clk) disable iff (!arst_n)
    data_out_valid && !data_out_ready |=>
      data_out_valid && $stable(mdata_out) && $stable(edata_out))
    else $error("output block changed or dropped while stalled");

  // One cycle from input transfer to output valid
  assert property (@(posedge clk) disable iff (!arst_n)
    data_in_valid && data_in_ready && data_out_ready |=> data_out_valid)
    else $error("data_out_valid missing one cycle after input transfer");

endmodule

bind mxint_cast_top mxint_cast_sva mxint_cast_sva_i (
  .clk            (clk),
  .arst_n         (arst_n),
  .data_in_valid  (data_in_valid),
  .data_in_ready  (data_in_ready),
  .mdata_out      (mdata_out),
  .edata_out      (edata_out),
  .data_out_valid (data_out_valid),
  .data_out_ready (data_out_ready)
);

// File: testbench/tb_mxint_cast.sv
`timescale 1ns/1ps

`include "mx_params.svh"

module tb_mxint_cast;

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 16;
  localparam int MAX_VEC        = 64;
  localparam int CYCLES_PER_VEC = 20;
  localparam int MW_IN          = `MX_BLOCK_SIZE * `MX_IN_MAN_WIDTH;
  localparam int MW_OUT         = `MX_BLOCK_SIZE * `MX_OUT_MAN_WIDTH;
  localparam int OW             = `MX_OUT_MAN_WIDTH;

  logic              clk = 1'b0;
  logic              arst_n;
  logic [MW_IN-1:0]  mdata_in;
  mx_pkg::in_exp_t   edata_in;
  logic              data_in_valid;
  logic              data_in_ready;
  logic [MW_OUT-1:0] mdata_out;
  mx_pkg::out_exp_t  edata_out;
  logic              data_out_valid;
  logic              data_out_ready;

  // Vectors from the data file
  logic [MW_IN-1:0]  in_mdata  [MAX_VEC];
  mx_pkg::in_exp_t   in_exp    [MAX_VEC];
  logic [MW_OUT-1:0] exp_mdata [MAX_VEC];
  mx_pkg::out_exp_t  exp_exp   [MAX_VEC];
  int                num_vec = 0;

  int     exp_q [$];  // Indices of blocks in flight
  int     received = 0;
  bit     ready_random = 1'b0;
  integer seed = 32'h9e7b_7bc0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  mxint_cast_top mxint_cast_top_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .mdata_in       (mdata_in),
    .edata_in       (edata_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .mdata_out      (mdata_out),
    .edata_out      (edata_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

  // ==========================================================================
  // Helpers
  // ==========================================================================

  task automatic fail_run();
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      fail_run();
    end
  endtask

  task automatic load_vectors();
    int         fd;
    int         n;
    string      line;
    logic [7:0] m0, m1, m2, m3, ei, eo;
    logic [3:0] o0, o1, o2, o3;
    fd = $fopen("testbench/mxint_cast_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/mxint_cast_input.txt");
      fail_run();
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;  // Comments, blank lines
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                  m0, m1, m2, m3, ei, o0, o1, o2, o3, eo);
      if (n != 10 || num_vec == MAX_VEC) begin
        $display("Stimulus file has a malformed line or too many blocks");
        fail_run();
      end
      in_mdata[num_vec]  = {m3, m2, m1, m0};  // Element 0 in the low bits
      in_exp[num_vec]    = ei[`MX_IN_EXP_WIDTH-1:0];
      exp_mdata[num_vec] = {o3, o2, o1, o0};
      exp_exp[num_vec]   = eo[`MX_OUT_EXP_WIDTH-1:0];
      num_vec++;
    end
    $fclose(fd);
    if (num_vec == 0) begin
      $display("Stimulus file holds no blocks");
      fail_run();
    end
  endtask

  // Sends every block once, holding valid and data until accepted
  task automatic drive_blocks(input bit gaps);
    int idx;
    bit fire;
    bit send;
    idx  = 0;
    fire = 1'b0;
    // Gap draw made off the rising edge
    send = !gaps || ($random(seed) & 3) != 0;
    while (idx < num_vec) begin
      @(posedge clk);
      if (fire) idx++;
      if (data_in_valid && !fire) begin
        // Hold until taken
      end else if (idx < num_vec && send) begin
        mdata_in      <= in_mdata[idx];
        edata_in      <= in_exp[idx];
        data_in_valid <= 1'b1;
      end else begin
        data_in_valid <= 1'b0;
      end
      @(negedge clk);
      if (!gaps && data_in_valid) begin
        check_value("data_in_ready", 32'(data_in_ready), 32'd1);
      end
      fire = data_in_valid && data_in_ready;
      if (fire) exp_q.push_back(idx);
      send = !gaps || ($random(seed) & 3) != 0;
    end
  endtask

  // ==========================================================================
  // Processes
  // ==========================================================================

  initial begin : out_ready_drive
    data_out_ready = 1'b0;
    forever begin
      @(posedge clk);
      if (ready_random) begin
        data_out_ready <= ($random(seed) & 1) != 0;
      end else begin
        data_out_ready <= arst_n;
      end
    end
  end

  initial begin : scoreboard
    int idx;
    forever begin
      @(negedge clk);
      if (arst_n && data_out_valid && data_out_ready) begin
        if (exp_q.size() == 0) begin
          $display("An output block arrived when none was expected");
          fail_run();
        end
        idx = exp_q.pop_front();
        for (int i = 0; i < `MX_BLOCK_SIZE; i++) begin
          check_value($sformatf("mdata_out[%0d]", i), 32'(mdata_out[i*OW +: OW]),
                      32'(exp_mdata[idx][i*OW +: OW]));
        end
        check_value("edata_out", 32'($unsigned(edata_out)),
                    32'($unsigned(exp_exp[idx])));
        received++;
      end
    end
  end

  initial begin : watchdog
    int timeout_cycles;
    wait (num_vec > 0);
    timeout_cycles = RESET_CYCLES + 2 * num_vec * CYCLES_PER_VEC;
    #(timeout_cycles * CLK_PERIOD);
    $display("Timeout: outputs stopped arriving, %0d of %0d blocks received",
             received, 2 * num_vec);
    fail_run();
  end

  initial begin : main
    arst_n        = 1'b0;
    mdata_in      = '0;
    edata_in      = '0;
    data_in_valid = 1'b0;
    load_vectors();
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_value("data_in_ready", 32'(data_in_ready), 32'd1);
    check_value("data_out_valid", 32'(data_out_valid), 32'd0);

    // Random input gaps and random back-pressure
    ready_random = 1'b1;
    drive_blocks(1'b1);
    wait (received == num_vec);

    // Back to back with the output always ready
    ready_random = 1'b0;
    repeat (2) @(posedge clk);
    drive_blocks(1'b0);
    wait (received == 2 * num_vec);
    repeat (4) @(posedge clk);  // Room for a duplicate to show up

    if (exp_q.size() == 0 && received == 2 * num_vec) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("SIMULATION FAILED");
      $fatal(1, "Blocks missing or checks failed");
    end
  end

endmodule

// File: verilog.f
+incdir+include
verilog/mx_pkg.sv
verilog/mx_block_if.sv
verilog/log2_max_abs.sv
verilog/mx_block_fifo.sv
verilog/mxint_cast.sv
verilog/mxint_cast_top.sv
testbench/mxint_cast_sva.sv
testbench/tb_mxint_cast.sv

// File: verilog/log2_max_abs.sv
`timescale 1ns/1ps

`include "mx_params.svh"

module log2_max_abs (
  input  logic              clk,
  input  logic              arst_n,
  input  mx_pkg::in_man_t   in_mant [`MX_BLOCK_SIZE],
  input  logic              in_valid,
  output logic              in_ready,
  output mx_pkg::log2_t     log2,
  output logic              out_valid,
  input  logic              out_ready
);

  localparam int BS = `MX_BLOCK_SIZE;
  localparam int W  = `MX_IN_MAN_WIDTH;

  logic [W-1:0]  mag [BS];
  logic [W-1:0]  or_mag;
  mx_pkg::log2_t msb;

  // Magnitudes as unsigned, so the most negative value gives 2**(W-1)
  for (genvar i = 0; i < BS; i++) begin : g_abs
    assign mag[i] = in_mant[i][W-1] ? $unsigned(-in_mant[i]) : $unsigned(in_mant[i]);
  end

  // Same top bit as the largest magnitude
  always_comb begin
    or_mag = '0;
    for (int i = 0; i < BS; i++) begin
      or_mag = or_mag | mag[i];
    end
  end

  // Highest set bit wins, zero block stays 0
  always_comb begin
    msb = '0;
    for (int b = 0; b < W; b++) begin
      if (or_mag[b]) begin
        msb = mx_pkg::log2_t'(b);
      end
    end
  end

  // ==========================================================================
  // One-entry output hold
  // ==========================================================================

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      log2 <= msb;
    end
  end

endmodule

// File: verilog/mx_block_fifo.sv
`timescale 1ns/1ps

`include "mx_params.svh"

module mx_block_fifo (
  input logic     clk,
  input logic     arst_n,
  mx_block_if.snk wr,
  mx_block_if.src rd
);

  localparam int DEPTH = `MX_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  // Mantissas and exponent of one block share an entry
  mx_pkg::in_man_t mem_mant [DEPTH][`MX_BLOCK_SIZE];
  mx_pkg::in_exp_t mem_exp  [DEPTH];

  logic [AW:0] wr_ptr;  // MSB is the wrap bit
  logic [AW:0] rd_ptr;
  logic        empty;
  logic        full;
  logic        do_wr;
  logic        do_rd;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign wr.ready = !full;
  assign do_wr    = wr.valid && !full;

  assign rd.valid = !empty;
  assign do_rd    = rd.ready && !empty;

  // Head entry straight from the storage flops
  assign rd.mant = mem_mant[rd_ptr[AW-1:0]];
  assign rd.exp  = mem_exp[rd_ptr[AW-1:0]];

  // ==========================================================================
  // Pointers
  // ==========================================================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // ==========================================================================
  // Storage
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem_mant[wr_ptr[AW-1:0]] <= wr.mant;
      mem_exp[wr_ptr[AW-1:0]]  <= wr.exp;
    end
  end

endmodule

// File: verilog/mx_block_if.sv
`timescale 1ns/1ps

`include "mx_params.svh"

interface mx_block_if #(
  parameter type man_t = mx_pkg::in_man_t,
  parameter type exp_t = mx_pkg::in_exp_t
);

  man_t mant [`MX_BLOCK_SIZE];  // Element 0 first
  exp_t exp;                    // Shared exponent
  logic valid;
  logic ready;

  // Producer side
  modport src (
    output mant,
    output exp,
    output valid,
    input  ready
  );

  // Consumer side
  modport snk (
    input  mant,
    input  exp,
    input  valid,
    output ready
  );

endinterface

// File: verilog/mx_pkg.sv
`include "mx_params.svh"

package mx_pkg;

  // Wide enough to hold the value MX_IN_MAN_WIDTH itself
  localparam int LOG2_WIDTH = $clog2(`MX_IN_MAN_WIDTH) + 1;

  // ==========================================================================
  // Input side
  // ==========================================================================

  typedef logic signed [`MX_IN_MAN_WIDTH-1:0] in_man_t;
  typedef logic signed [`MX_IN_EXP_WIDTH-1:0] in_exp_t;

  // ==========================================================================
  // Output side
  // ==========================================================================

  typedef logic signed [`MX_OUT_MAN_WIDTH-1:0] out_man_t;
  typedef logic signed [`MX_OUT_EXP_WIDTH-1:0] out_exp_t;

  // Floor log2 of the largest magnitude
  typedef logic [LOG2_WIDTH-1:0] log2_t;

endpackage

// File: verilog/mxint_cast.sv
`timescale 1ns/1ps

`include "mx_params.svh"

module mxint_cast (
  input logic     clk,
  input logic     arst_n,
  mx_block_if.snk blk_in,
  mx_block_if.src blk_out
);

  localparam int BS        = `MX_BLOCK_SIZE;
  localparam int IN_MAN_W  = `MX_IN_MAN_WIDTH;
  localparam int IN_EXP_W  = `MX_IN_EXP_WIDTH;
  localparam int OUT_MAN_W = `MX_OUT_MAN_WIDTH;
  localparam int OUT_EXP_W = `MX_OUT_EXP_WIDTH;
  localparam int EW        = IN_EXP_W + OUT_EXP_W + mx_pkg::LOG2_WIDTH;  // Lossless
  localparam int SW        = IN_MAN_W + OUT_MAN_W;

  localparam logic signed [EW-1:0] EXP_OFFSET = EW'(`MX_EXP_OFFSET);
  localparam logic signed [EW-1:0] EXP_MAX    = EW'((1 << (OUT_EXP_W - 1)) - 1);
  localparam logic signed [EW-1:0] EXP_MIN    = -EXP_MAX - 1;
  localparam logic signed [SW-1:0] MAN_MAX    = SW'((1 << (OUT_MAN_W - 1)) - 1);
  localparam logic signed [SW-1:0] MAN_MIN    = -MAN_MAX - 1;
  // Past these amounts the clamped result no longer changes
  localparam logic [EW-1:0]        RSH_CAP    = EW'(IN_MAN_W - 1);
  localparam logic [EW-1:0]        LSH_CAP    = EW'(OUT_MAN_W);

  mx_block_if buf_in ();
  mx_block_if buf_out ();

  logic          log2_in_valid;
  logic          log2_in_ready;
  mx_pkg::log2_t log2_val;
  logic          log2_valid;
  logic          log2_out_ready;

  // ==========================================================================
  // Split into log2 branch and block buffer
  // ==========================================================================

  assign buf_in.mant   = blk_in.mant;
  assign buf_in.exp    = blk_in.exp;
  assign buf_in.valid  = blk_in.valid && log2_in_ready;
  assign log2_in_valid = blk_in.valid && buf_in.ready;
  assign blk_in.ready  = log2_in_ready && buf_in.ready;  // Both take it together

  log2_max_abs log2_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_mant   (blk_in.mant),
    .in_valid  (log2_in_valid),
    .in_ready  (log2_in_ready),
    .log2      (log2_val),
    .out_valid (log2_valid),
    .out_ready (log2_out_ready)
  );

  mx_block_fifo fifo_i (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (buf_in.snk),
    .rd     (buf_out.src)
  );

  // Join
  assign blk_out.valid  = log2_valid && buf_out.valid;
  assign log2_out_ready = blk_out.ready && buf_out.valid;
  assign buf_out.ready  = blk_out.ready && log2_valid;

  // ==========================================================================
  // New exponent
  // ==========================================================================

  logic signed [EW-1:0] exp_ext;
  logic signed [EW-1:0] log2_ext;
  logic signed [EW-1:0] exp_full;
  logic signed [EW-1:0] exp_new;
  logic signed [EW-1:0] shift;
  logic        [EW-1:0] shift_abs;
  logic        [EW-1:0] rsh_amt;
  logic        [EW-1:0] lsh_amt;
  logic                 shift_neg;

  assign exp_ext  = EW'(buf_out.exp);  // Sign extended
  assign log2_ext = EW'(log2_val);
  assign exp_full = exp_ext + log2_ext - EXP_OFFSET;

  always_comb begin
    if (exp_full > EXP_MAX) begin
      exp_new = EXP_MAX;
    end else if (exp_full < EXP_MIN) begin
      exp_new = EXP_MIN;
    end else begin
      exp_new = exp_full;
    end
  end

  assign blk_out.exp = exp_new[OUT_EXP_W-1:0];

  assign shift     = exp_new - exp_ext;
  assign shift_neg = shift[EW-1];  // Negative means shift left
  assign shift_abs = shift_neg ? $unsigned(-shift) : $unsigned(shift);
  assign rsh_amt   = (shift_abs > RSH_CAP) ? RSH_CAP : shift_abs;
  assign lsh_amt   = (shift_abs > LSH_CAP) ? LSH_CAP : shift_abs;

  // ==========================================================================
  // Mantissa shift and clamp
  // ==========================================================================

  for (genvar i = 0; i < BS; i++) begin : g_man
    logic signed [SW-1:0] man_ext;
    logic signed [SW-1:0] man_sh;
    mx_pkg::out_man_t     man_clamp;

    assign man_ext = SW'(buf_out.mant[i]);
    // Arithmetic right shift floors negative values
    assign man_sh  = shift_neg ? (man_ext <<< lsh_amt) : (man_ext >>> rsh_amt);

    always_comb begin
      if (man_sh > MAN_MAX) begin
        man_clamp = MAN_MAX[OUT_MAN_W-1:0];
      end else if (man_sh < MAN_MIN) begin
        man_clamp = MAN_MIN[OUT_MAN_W-1:0];
      end else begin
        man_clamp = man_sh[OUT_MAN_W-1:0];
      end
    end

    assign blk_out.mant[i] = man_clamp;
  end

endmodule

// File: verilog/mxint_cast_top.sv
`timescale 1ns/1ps

`include "mx_params.svh"

module mxint_cast_top (
  input  logic                                          clk,
  input  logic                                          arst_n,
  input  logic [`MX_BLOCK_SIZE*`MX_IN_MAN_WIDTH-1:0]    mdata_in,
  input  mx_pkg::in_exp_t                               edata_in,
  input  logic                                          data_in_valid,
  output logic                                          data_in_ready,
  output logic [`MX_BLOCK_SIZE*`MX_OUT_MAN_WIDTH-1:0]   mdata_out,
  output mx_pkg::out_exp_t                              edata_out,
  output logic                                          data_out_valid,
  input  logic                                          data_out_ready
);

  localparam int IW = `MX_IN_MAN_WIDTH;
  localparam int OW = `MX_OUT_MAN_WIDTH;

  mx_block_if in_if ();
  mx_block_if #(
    .man_t (mx_pkg::out_man_t),
    .exp_t (mx_pkg::out_exp_t)
  ) out_if ();

  // Element 0 sits in the low bits
  for (genvar i = 0; i < `MX_BLOCK_SIZE; i++) begin : g_pack
    assign in_if.mant[i]         = mdata_in[i*IW +: IW];
    assign mdata_out[i*OW +: OW] = out_if.mant[i];
  end

  assign in_if.exp     = edata_in;
  assign in_if.valid   = data_in_valid;
  assign data_in_ready = in_if.ready;

  assign edata_out      = out_if.exp;
  assign data_out_valid = out_if.valid;
  assign out_if.ready   = data_out_ready;

  mxint_cast cast_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .blk_in  (in_if.snk),
    .blk_out (out_if.src)
  );

endmodule
